// File: logic/icache_pkg.sv
//********************
// shared types and constants for the instruction cache
// import with a wildcard in the module header
// cache geometry is set by module parameters on the top level
//********************
`default_nettype none

package icache_pkg;

    typedef logic [31:0] addr_t; // physical byte address
    typedef logic [31:0] word_t; // one instruction

    localparam int unsigned BYTES_PER_WORD = 4;
    localparam int unsigned BYTE_OFF_W     = $clog2(BYTES_PER_WORD); // byte-in-word bits

    // controller states
    // the miss path waits for the request to be taken, then for the line,
    // then spends one cycle re-reading the stores before the lookup ends
    typedef enum logic [2:0] {
        LOOKUP,
        MISS_REQ,    // refill_req high until refill_rdy
        MISS_WAIT,   // line arrives with refill_valid
        REFILL_DONE, // stores re-read at the buffered index
        UNC_REQ,     // unc_req high until unc_rdy
        UNC_WAIT,    // word arrives with unc_valid
        UNC_DONE     // uncached word returned to the fetch stage
    } icache_state_e;

endpackage

`default_nettype wire

// File: logic/icache_tag_store.sv
//********************
// valid bits and tags for every set of every way
// one registered read port shared with the refill write
// all ways are read at once, result one cycle after rd_index
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_tag_store
    import icache_pkg::*;
#(
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned WAYS       = 4,
    parameter int unsigned SETS       = 64,
    localparam int unsigned OFFSET_W  = $clog2(LINE_WORDS * BYTES_PER_WORD),
    localparam int unsigned INDEX_W   = $clog2(SETS),
    localparam int unsigned TAG_W     = 32 - INDEX_W - OFFSET_W
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire  [INDEX_W-1:0]            rd_index,
    input  wire  [WAYS-1:0]               tag_we,   // one-hot refill way
    input  wire  [TAG_W-1:0]              fill_tag,
    output logic [WAYS-1:0]               tag_rvalid,
    output logic [WAYS-1:0][TAG_W-1:0]    tag_rtag
);

    logic [SETS-1:0]  valid_bits [WAYS];
    logic [TAG_W-1:0] tags       [WAYS][SETS];

    // tag arrays, old contents come out on a write cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (tag_we[w]) begin
                tags[w][rd_index] <= fill_tag;
            end
            tag_rtag[w] <= tags[w][rd_index];
        end
    end

    // valid bits are cleared by reset, set by a refill
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_bits[w] <= '0;
            end
            tag_rvalid <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (tag_we[w]) begin
                    valid_bits[w][rd_index] <= 1'b1;
                end
                tag_rvalid[w] <= valid_bits[w][rd_index];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_data_store.sv
//********************
// line storage for every set of every way
// a refill writes the whole line into one way
// reads return all ways one cycle after rd_index
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_data_store
    import icache_pkg::*;
#(
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned WAYS       = 4,
    parameter int unsigned SETS       = 64,
    localparam int unsigned INDEX_W   = $clog2(SETS),
    localparam int unsigned LINE_W    = LINE_WORDS * $bits(word_t)
) (
    input  wire                         clk,
    input  wire  [INDEX_W-1:0]          rd_index,
    input  wire  [WAYS-1:0]             data_we,     // one-hot refill way
    input  wire  [LINE_W-1:0]           refill_data,
    output logic [WAYS-1:0][LINE_W-1:0] data_rline
);

    logic [LINE_W-1:0] lines [WAYS][SETS];

    // word 0 of a line sits in the low bits
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (data_we[w]) begin
                lines[w][rd_index] <= refill_data;
            end
            data_rline[w] <= lines[w][rd_index]; // read before write
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_plru.sv
//********************
// tree pseudo-LRU state, WAYS-1 bits per set
// lru_update marks an access of hit_way in set rd_index
// victim_way is the one-hot way the tree points at
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_plru #(
    parameter int unsigned WAYS      = 4, // power of two
    parameter int unsigned SETS      = 64,
    localparam int unsigned INDEX_W  = $clog2(SETS),
    localparam int unsigned LEVELS   = $clog2(WAYS)
) (
    input  wire                clk,
    input  wire                reset,
    input  wire  [INDEX_W-1:0] rd_index,
    input  wire                lru_update,
    input  wire  [WAYS-1:0]    hit_way,    // one-hot
    output logic [WAYS-1:0]    victim_way  // one-hot
);

    // node n has children 2n+1 (bit 0) and 2n+2 (bit 1)
    logic [WAYS-2:0] tree [SETS];
    logic [WAYS-2:0] tree_next;

    // walk down the tree following the bits
    always_comb begin
        int unsigned node;
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            node = 2 * node + 1 + int'(tree[rd_index][node]);
        end
        victim_way = '0;
        victim_way[node - (WAYS - 1)] = 1'b1;
    end

    // every node on the accessed path points away from it
    always_comb begin
        int unsigned way;
        int unsigned node;
        way = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_way[w]) begin
                way = w;
            end
        end
        tree_next = tree[rd_index];
        for (int l = 0; l < LEVELS; l++) begin
            node = (1 << l) - 1 + (way >> (LEVELS - l));
            tree_next[node] = !way[LEVELS-1-l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (lru_update) begin
            tree[rd_index] <= tree_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_ctrl.sv
//********************
// cache controller: request buffer, hit check, word select
// sequences line refills on a miss and single uncached reads
// a hit answers in the cycle after the request is taken
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned WAYS       = 4,
    parameter int unsigned SETS       = 64,
    localparam int unsigned OFFSET_W  = $clog2(LINE_WORDS * BYTES_PER_WORD),
    localparam int unsigned INDEX_W   = $clog2(SETS),
    localparam int unsigned TAG_W     = 32 - INDEX_W - OFFSET_W,
    localparam int unsigned WSEL_W    = OFFSET_W - BYTE_OFF_W,
    localparam int unsigned LINE_W    = LINE_WORDS * $bits(word_t)
) (
    input  wire                         clk,
    input  wire                         reset,
    // fetch side
    input  wire                         cpu_valid,
    input  wire  addr_t                 cpu_addr,
    input  wire                         cpu_cached,
    input  wire                         cpu_stall,
    input  wire                         cpu_flush,
    output logic                        cpu_busy,
    output logic                        cpu_resp_valid,
    output word_t                       cpu_rdata,
    // line refill
    output logic                        refill_req,
    output addr_t                       refill_addr,
    input  wire                         refill_rdy,
    input  wire                         refill_valid,
    // uncached read
    output logic                        unc_req,
    output addr_t                       unc_addr,
    input  wire                         unc_rdy,
    input  wire                         unc_valid,
    input  wire  word_t                 unc_data,
    // stores
    output logic [INDEX_W-1:0]          rd_index,
    output logic [WAYS-1:0]             tag_we,
    output logic [WAYS-1:0]             data_we,
    output logic [TAG_W-1:0]            fill_tag,
    input  wire  [WAYS-1:0]             tag_rvalid,
    input  wire  [WAYS-1:0][TAG_W-1:0]  tag_rtag,
    input  wire  [WAYS-1:0][LINE_W-1:0] data_rline,
    // replacement
    output logic [INDEX_W-1:0]          lru_index,
    output logic                        lru_update,
    output logic [WAYS-1:0]             hit_way,
    input  wire  [WAYS-1:0]             victim_way
);

    icache_state_e state, state_next;

    logic              buf_valid;
    logic              buf_cached;
    addr_t             buf_addr;
    word_t             unc_word;   // last uncached word
    logic [TAG_W-1:0]  buf_tag;
    logic [INDEX_W-1:0] buf_index;
    logic [WSEL_W-1:0] buf_word;
    logic [WAYS-1:0]   hit;
    logic [LINE_W-1:0] hit_line;
    logic              lookup_hit;
    logic              load_en;
    logic              fill_now;

    assign buf_tag   = buf_addr[31 -: TAG_W];
    assign buf_index = buf_addr[OFFSET_W +: INDEX_W];
    assign buf_word  = buf_addr[BYTE_OFF_W +: WSEL_W];

    // tag compare against every way, line of the hit way
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = tag_rvalid[w] && (tag_rtag[w] == buf_tag);
            if (hit[w]) begin
                hit_line = hit_line | data_rline[w];
            end
        end
    end

    always_comb begin
        case (state)
            LOOKUP:   cpu_busy = buf_valid && (!buf_cached || !(|hit));
            UNC_DONE: cpu_busy = 1'b0;
            default:  cpu_busy = 1'b1;
        endcase
    end

    assign lookup_hit     = (state == LOOKUP) && buf_valid && buf_cached && (|hit);
    assign cpu_resp_valid = !cpu_flush && (lookup_hit || (state == UNC_DONE && buf_valid));
    assign cpu_rdata      = (state == UNC_DONE) ? unc_word
                                                : hit_line[buf_word * $bits(word_t) +: 32];

    // while busy or stalled the stores keep reading the buffered set,
    // so the registered tags and lines hold still
    assign load_en  = !cpu_busy && !cpu_stall;
    assign rd_index = load_en ? cpu_addr[OFFSET_W +: INDEX_W] : buf_index;

    // refill writes the victim way and counts as its access
    assign fill_now   = (state == MISS_WAIT) && refill_valid;
    assign tag_we     = fill_now ? victim_way : '0;
    assign data_we    = fill_now ? victim_way : '0;
    assign fill_tag   = buf_tag;
    assign lru_index  = buf_index;
    assign lru_update = fill_now || (lookup_hit && !cpu_stall && !cpu_flush);
    assign hit_way    = fill_now ? victim_way : hit;

    assign refill_req  = (state == MISS_REQ);
    assign refill_addr = {buf_addr[31:OFFSET_W], {OFFSET_W{1'b0}}}; // line aligned
    assign unc_req     = (state == UNC_REQ);
    assign unc_addr    = {buf_addr[31:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};

    // flush drops only the valid bit, a refill in flight still needs the tag
    always_ff @(posedge clk) begin
        if (reset || cpu_flush) begin
            buf_valid <= 1'b0;
        end else if (load_en) begin
            buf_valid <= cpu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            buf_cached <= cpu_cached;
            buf_addr   <= cpu_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (state == UNC_WAIT && unc_valid) begin
            unc_word <= unc_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (buf_valid && !cpu_flush) begin
                    if (!buf_cached) begin
                        state_next = UNC_REQ;
                    end else if (!(|hit)) begin
                        state_next = MISS_REQ;
                    end
                end
            end
            MISS_REQ:    state_next = refill_rdy ? MISS_WAIT : MISS_REQ;
            MISS_WAIT:   state_next = refill_valid ? REFILL_DONE : MISS_WAIT;
            REFILL_DONE: state_next = LOOKUP; // stores re-read, hit next cycle
            UNC_REQ:     state_next = unc_rdy ? UNC_WAIT : UNC_REQ;
            UNC_WAIT:    state_next = unc_valid ? UNC_DONE : UNC_WAIT;
            UNC_DONE:    state_next = cpu_stall ? UNC_DONE : LOOKUP;
            default:     state_next = LOOKUP;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/icache_top.sv
//********************
// four-way set-associative instruction cache
// sets the cache geometry and wires the controller
// to the tag store, data store and PLRU state
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned WAYS       = 4,
    parameter int unsigned SETS       = 64,
    localparam int unsigned OFFSET_W  = $clog2(LINE_WORDS * BYTES_PER_WORD),
    localparam int unsigned INDEX_W   = $clog2(SETS),
    localparam int unsigned TAG_W     = 32 - INDEX_W - OFFSET_W,
    localparam int unsigned LINE_W    = LINE_WORDS * $bits(word_t)
) (
    input  wire               clk,
    input  wire               reset,
    input  wire               cpu_valid,
    input  wire  addr_t       cpu_addr,
    input  wire               cpu_cached,
    input  wire               cpu_stall,
    input  wire               cpu_flush,
    output logic              cpu_busy,
    output logic              cpu_resp_valid,
    output word_t             cpu_rdata,
    output logic              refill_req,
    output addr_t             refill_addr,
    input  wire               refill_rdy,
    input  wire               refill_valid,
    input  wire  [LINE_W-1:0] refill_data,  // whole line, word 0 low
    output logic              unc_req,
    output addr_t             unc_addr,
    input  wire               unc_rdy,
    input  wire               unc_valid,
    input  wire  word_t       unc_data
);

    logic [INDEX_W-1:0]          rd_index;
    logic [INDEX_W-1:0]          lru_index;
    logic [WAYS-1:0]             tag_we;
    logic [WAYS-1:0]             data_we;
    logic [TAG_W-1:0]            fill_tag;
    logic [WAYS-1:0]             tag_rvalid;
    logic [WAYS-1:0][TAG_W-1:0]  tag_rtag;
    logic [WAYS-1:0][LINE_W-1:0] data_rline;
    logic                        lru_update;
    logic [WAYS-1:0]             hit_way;
    logic [WAYS-1:0]             victim_way;

    icache_ctrl #(.LINE_WORDS(LINE_WORDS), .WAYS(WAYS), .SETS(SETS)) u_ctrl (.*);

    icache_tag_store #(.LINE_WORDS(LINE_WORDS), .WAYS(WAYS), .SETS(SETS)) u_tags (
        .clk, .reset, .rd_index, .tag_we, .fill_tag, .tag_rvalid, .tag_rtag
    );

    icache_data_store #(.LINE_WORDS(LINE_WORDS), .WAYS(WAYS), .SETS(SETS)) u_data (
        .clk, .rd_index, .data_we, .refill_data, .data_rline
    );

    // replacement state follows the buffered request, not the read index
    icache_plru #(.WAYS(WAYS), .SETS(SETS)) u_plru (
        .clk,
        .reset,
        .rd_index   (lru_index),
        .lru_update,
        .hit_way,
        .victim_way
    );

endmodule

`default_nettype wire

// File: verification/icache_checker.sv
//********************
// watches the cache ports and scores every fetch
// keeps its own model of line contents and tree PLRU
// one line per finished test, counts go back to the testbench
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_checker (
    input  wire        clk,
    input  wire        reset,
    input  wire        cpu_valid,
    input  wire [31:0] cpu_addr,
    input  wire        cpu_cached,
    input  wire        cpu_stall,
    input  wire        cpu_flush,
    input  wire        cpu_busy,
    input  wire        cpu_resp_valid,
    input  wire [31:0] cpu_rdata,
    input  wire        refill_req,
    input  wire        refill_rdy,
    input  wire [31:0] refill_addr,
    input  wire        unc_req,
    input  wire        unc_rdy,
    input  wire [31:0] unc_addr,
    output int         done_count,
    output int         pass_count,
    output int         fail_count
);

    logic [31:0] q_addr [$];    // accepted, not yet answered
    logic        q_cached [$];
    logic [27:0] line_tag [64][4];
    logic        line_ok [64][4];
    logic [2:0]  tree [64];     // bit 0 root, 1 left pair, 2 right pair
    int          refills, uncs, waited, errs;
    logic        held;
    logic [31:0] held_data;

    function automatic int victim(input logic [2:0] t);
        return t[0] ? (t[2] ? 3 : 2) : (t[1] ? 1 : 0);
    endfunction

    // point every bit on the path away from way w
    function automatic logic [2:0] touch(input logic [2:0] t, input int w);
        logic [2:0] r;
        r = t;
        r[0] = (w < 2);
        if (w < 2) r[1] = (w == 0);
        else r[2] = (w == 2);
        return r;
    endfunction

    task automatic error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errs++;
    endtask

    task automatic close_test(input logic [31:0] a, input string what);
        if (errs == 0) begin
            $display("test %0d %s at %h passed", done_count + 1, what, a);
            pass_count <= pass_count + 1;
        end else begin
            $display("test %0d %s at %h failed", done_count + 1, what, a);
            fail_count <= fail_count + 1;
        end
        done_count <= done_count + 1;
        errs = 0;
        refills = 0;
        uncs = 0;
        waited = 0;
    endtask

    task automatic finish_head();
        logic [31:0] a;
        logic [31:0] exp;
        logic        c;
        int          set;
        int          way;
        a = q_addr.pop_front();
        c = q_cached.pop_front();
        set = a[9:4];
        way = -1;
        for (int w = 0; w < 4; w++) begin
            if (line_ok[set][w] && line_tag[set][w] == a[31:4]) way = w;
        end
        exp = c ? ~a : a; // memory holds inverted addresses
        if (cpu_rdata !== exp) begin
            error($sformatf("read %h at %h, expected %h", cpu_rdata, a, exp));
        end
        if (refills != ((c && way < 0) ? 1 : 0)) begin
            error($sformatf("%0d refills for %h", refills, a));
        end
        if (uncs != (c ? 0 : 1)) begin
            error($sformatf("%0d uncached reads for %h", uncs, a));
        end
        if (c && way >= 0 && waited != 0) begin
            error($sformatf("hit at %h answered late", a));
        end
        if (c) begin
            if (way < 0) begin
                way = victim(tree[set]);
                line_tag[set][way] = a[31:4];
                line_ok[set][way] = 1'b1;
            end
            tree[set] = touch(tree[set], way);
        end
        close_test(a, c ? "cached fetch" : "uncached fetch");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            q_addr.delete();
            q_cached.delete();
            for (int s = 0; s < 64; s++) begin
                tree[s] = '0;
                for (int w = 0; w < 4; w++) line_ok[s][w] = 1'b0;
            end
            {refills, uncs, waited, errs} = '0;
            held = 1'b0;
            done_count <= 0;
            pass_count <= 0;
            fail_count <= 0;
        end else begin
            if (held && (!cpu_resp_valid || cpu_rdata !== held_data)) begin
                error("response changed while stalled");
            end
            held = cpu_resp_valid && cpu_stall;
            held_data = cpu_rdata;
            if (refill_req && refill_rdy) begin
                refills++;
                if (q_addr.size() == 0) begin
                    error($sformatf("refill of %h with no fetch pending", refill_addr));
                end else if (refill_addr !== (q_addr[0] & ~32'hf)) begin
                    error($sformatf("refill address %h for fetch at %h",
                                    refill_addr, q_addr[0]));
                end
            end
            if (unc_req && unc_rdy) begin
                uncs++;
                if (q_addr.size() == 0) begin
                    error($sformatf("uncached read of %h with no fetch pending", unc_addr));
                end else if (unc_addr !== (q_addr[0] & ~32'h3)) begin
                    error($sformatf("uncached address %h for fetch at %h",
                                    unc_addr, q_addr[0]));
                end
            end
            if (q_addr.size() > 0) begin
                if (cpu_flush) begin
                    if (cpu_resp_valid) begin
                        error("response given for a flushed fetch");
                    end
                    void'(q_cached.pop_front());
                    close_test(q_addr.pop_front(), "flushed fetch");
                end else if (cpu_resp_valid && !cpu_stall) begin
                    finish_head();
                end else if (!cpu_stall) begin
                    waited++;
                end
            end else if (cpu_resp_valid) begin
                $display("** Error at %0t: response with no request pending", $time);
                fail_count <= fail_count + 1;
            end
            if (cpu_valid && !cpu_busy && !cpu_stall) begin // accepted this edge
                q_addr.push_back(cpu_addr);
                q_cached.push_back(cpu_cached);
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/icache_tb.sv
//********************
// testbench for the instruction cache
// applies a table of fetches, models refill and uncached memory
// memory word = inverted byte address, uncached word = address
//********************
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

    logic         clk, reset;
    logic         cpu_valid, cpu_cached, cpu_stall, cpu_flush;
    logic [31:0]  cpu_addr;
    logic         cpu_busy, cpu_resp_valid, refill_req, unc_req;
    logic [31:0]  cpu_rdata, refill_addr, unc_addr, unc_data;
    logic         refill_rdy, refill_valid, unc_rdy, unc_valid;
    logic [127:0] refill_data;
    int           done_count, pass_count, fail_count;
    int           seed = 77639;
    int           limit = 0;
    int           cycles = 0;

    // stimulus table, one entry per test
    logic [31:0] t_addr [$];
    bit          t_cached [$];
    int          t_stall [$];
    bit          t_flush [$];
    bit          t_chain [$]; // next entry follows at once

    icache_top #(.LINE_WORDS(4), .WAYS(4), .SETS(64)) DUT (.*);

    icache_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_test(input logic [31:0] a, input bit c, input int s, input bit f,
                            input bit ch);
        t_addr.push_back(a);
        t_cached.push_back(c);
        t_stall.push_back(s);
        t_flush.push_back(f);
        t_chain.push_back(ch);
    endtask

    // line refill after 1 to 4 cycles
    initial begin
        int          delay;
        logic [127:0] line;
        refill_rdy = 1'b0;
        refill_valid = 1'b0;
        refill_data = '0;
        forever begin
            @(posedge clk);
            if (refill_req) begin
                delay = 1 + ({$random(seed)} % 4);
                repeat (delay - 1) @(posedge clk);
                refill_rdy <= 1'b1;
                @(posedge clk);
                for (int k = 0; k < 4; k++) line[32*k +: 32] = ~(refill_addr + 4 * k);
                refill_rdy <= 1'b0;
                refill_valid <= 1'b1;
                refill_data <= line;
                @(posedge clk);
                refill_valid <= 1'b0;
            end
        end
    end

    initial begin
        unc_rdy = 1'b0;
        unc_valid = 1'b0;
        unc_data = '0;
        forever begin
            @(posedge clk);
            if (unc_req) begin
                unc_rdy <= 1'b1;
                @(posedge clk);
                unc_rdy <= 1'b0;
                unc_valid <= 1'b1;
                unc_data <= unc_addr;
                @(posedge clk);
                unc_valid <= 1'b0;
            end
        end
    end

    initial begin
        do begin
            @(posedge clk);
            cycles++;
        end while (limit == 0 || cycles <= limit);
        $display("timeout: tests did not finish within %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

    initial begin
        int i;
        {reset, cpu_valid, cpu_cached, cpu_stall, cpu_flush} = 5'b10000;
        cpu_addr = '0;
        add_test(32'h1000, 1, 0, 0, 0); // cold miss
        add_test(32'h1004, 1, 0, 0, 1); // streaming hits
        add_test(32'h1008, 1, 0, 0, 1);
        add_test(32'h100c, 1, 0, 0, 0);
        for (int k = 0; k < 5; k++) add_test(32'h2050 + 32'h400 * k, 1, 0, 0, 0); // set 5
        add_test(32'h2850, 1, 0, 0, 0); // third line still there
        add_test(32'h2050, 1, 0, 0, 0); // evicted by the fifth
        add_test(32'h4000, 0, 0, 0, 0);
        add_test(32'h4000, 1, 0, 0, 0);
        add_test(32'h1008, 1, 3, 0, 1); // stalled response
        add_test(32'h100c, 1, 0, 0, 0);
        add_test(32'h1004, 1, 0, 1, 0); // flushed hit
        add_test(32'h1000, 1, 0, 0, 0);
        limit = t_addr.size() * 20;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        i = 0;
        while (i < t_addr.size()) begin
            cpu_valid <= 1'b1;
            cpu_addr <= t_addr[i];
            cpu_cached <= t_cached[i];
            do @(posedge clk); while (cpu_busy || cpu_stall);
            if (!t_chain[i] || i == t_addr.size() - 1) cpu_valid <= 1'b0;
            if (t_flush[i]) begin
                cpu_flush <= 1'b1;
                @(posedge clk);
                cpu_flush <= 1'b0;
            end
            if (t_stall[i] > 0) begin
                cpu_stall <= 1'b1;
                if (t_chain[i] && i < t_addr.size() - 1) begin
                    cpu_addr <= t_addr[i+1]; // next fetch waits out the stall
                    cpu_cached <= t_cached[i+1];
                end
                repeat (t_stall[i]) @(posedge clk);
                cpu_stall <= 1'b0;
            end
            if (!t_chain[i]) begin
                while (done_count <= i) @(posedge clk);
            end
            i++;
        end
        repeat (2) @(posedge clk);
        $display("%0d tests: %0d passed, %0d failed", t_addr.size(), pass_count, fail_count);
        if (fail_count == 0 && pass_count == t_addr.size()) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_plru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verification/icache_checker.sv
verification/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_tag_store.sv
  - logic/icache_data_store.sv
  - logic/icache_plru.sv
  - logic/icache_ctrl.sv
  - logic/icache_top.sv
  - target: simulation
    files:
      - verification/icache_checker.sv
      - verification/icache_tb.sv
